// File: icache.f
source/icache_pkg.sv
source/icache_ctrl.sv
source/icache_tagv_ram.sv
source/icache_data_ram.sv
source/icache_lru.sv
source/icache_read_path.sv
source/icache_top.sv
verif/icache_assert.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/icache_ctrl.sv
  - source/icache_tagv_ram.sv
  - source/icache_data_ram.sv
  - source/icache_lru.sv
  - source/icache_read_path.sv
  - source/icache_top.sv
  - target: test
    files:
      - verif/icache_assert.sv
      - verif/icache_mem_model.sv
      - verif/icache_tb.sv

// File: verif/icache_tb.sv
`default_nettype none

module icache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          INDEX_WIDTH  = 4;
    localparam int          OFFSET_WIDTH = 2;
    localparam int          LINE_WIDTH   = icache_pkg::WORD_WIDTH * (2 ** OFFSET_WIDTH);
    localparam logic [31:0] PATTERN      = 32'h5a5a_0f0f;
    localparam int          PERIOD       = 40;
    localparam int          NUM_REQS     = 18;
    // miss with both memory delays at 3, plus stall holding
    localparam int          WORST_LAT    = 24;
    localparam int          TIMEOUT      = (NUM_REQS * WORST_LAT * 2 + 8) * PERIOD;

    logic                   clk;
    logic                   rstn;
    logic                   req_valid;
    icache_pkg::fetch_req_t req;
    icache_pkg::pipe_ctrl_t ctrl;
    logic                   req_ready;
    logic                   rdata_valid;
    logic [31:0]            rdata;
    logic                   mem_req;
    logic [31:0]            mem_addr;
    logic                   mem_addr_ok;
    logic                   mem_data_ok;
    logic [LINE_WIDTH-1:0]  mem_line;

    // per-request expectations travel with req
    logic        exp_miss;
    logic        exp_drop;
    logic        miss_allowed;
    logic [31:0] miss_line;
    logic [31:0] exp_word [16];
    logic [3:0]  head;
    logic [3:0]  tail;
    logic        accept;
    logic        deliver;

    assign accept  = req_valid && req_ready;
    assign deliver = rdata_valid && !ctrl.stall;

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    icache_top #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) icache_top_i (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req         (req),
        .ctrl        (ctrl),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line),
        .req_ready   (req_ready),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr)
    );

    icache_mem_model #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .PATTERN      (PATTERN)
    ) mem_model_i (
        .clk         (clk),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line)
    );

    bind icache_top icache_assert icache_assert_i (.*);

    task automatic fail_run();
        $display("Result: FAILED");
        $fatal(1, "stopping after the first error");
    endtask

    // pop one expected word per delivery
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            head <= '0;
        else if (deliver)
            head <= head + 1'b1;
    end

    // protocol checker failures end the run
    always @(posedge clk) begin
        if (icache_top_i.icache_assert_i.fail_count != 0) begin
            $display("a protocol check failed inside the cache");
            fail_run();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    no_extra: assert property (@(posedge clk) disable iff (!rstn)
        deliver |-> head != tail)
        else begin
            $display("rdata_valid delivered a word with no request pending");
            fail_run();
        end

    word_ok: assert property (@(posedge clk) disable iff (!rstn)
        (deliver && head != tail) |-> rdata == exp_word[head])
        else begin
            $display("mismatch rdata: got %h expected %h",
                     $sampled(rdata), $sampled(exp_word[head]));
            fail_run();
        end

    hit_latency: assert property (@(posedge clk) disable iff (!rstn)
        (accept && !exp_miss && !exp_drop && req.op == icache_pkg::ICACHE_FETCH)
        |=> rdata_valid)
        else begin
            $display("mismatch rdata_valid: got %h expected %h one cycle after a hit",
                     $sampled(rdata_valid), 1'b1);
            fail_run();
        end

    // hits stream at one acceptance per cycle
    hit_stream: assert property (@(posedge clk) disable iff (!rstn)
        (accept && !exp_miss && !exp_drop && req.op == icache_pkg::ICACHE_FETCH)
        |=> (req_ready || ctrl.stall))
        else begin
            $display("mismatch req_ready: got %h expected %h in the cycle after a hit",
                     $sampled(req_ready), 1'b1);
            fail_run();
        end

    miss_latency: assert property (@(posedge clk) disable iff (!rstn)
        (accept && exp_miss) |=> mem_req)
        else begin
            $display("mismatch mem_req: got %h expected %h one cycle after a miss",
                     $sampled(mem_req), 1'b1);
            fail_run();
        end

    refill_forward: assert property (@(posedge clk) disable iff (!rstn)
        mem_data_ok |-> rdata_valid)
        else begin
            $display("mismatch rdata_valid: got %h expected %h with mem_data_ok",
                     $sampled(rdata_valid), 1'b1);
            fail_run();
        end

    miss_only: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |-> miss_allowed)
        else begin
            $display("mem_req raised for a request that should not miss");
            fail_run();
        end

    line_addr: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |-> mem_addr == miss_line)
        else begin
            $display("mismatch mem_addr: got %h expected %h",
                     $sampled(mem_addr), $sampled(miss_line));
            fail_run();
        end

    inval_cycle: assert property (@(posedge clk) disable iff (!rstn)
        (accept && req.op == icache_pkg::ICACHE_INVALIDATE)
        |=> (!rdata_valid && !req_ready))
        else begin
            $display("invalidate cycle showed rdata_valid or req_ready");
            fail_run();
        end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic send_req(input logic [31:0] addr, input logic inval,
                            input logic miss, input logic drop, input logic stall);
        req_valid <= 1'b1;
        req.addr  <= addr;
        req.op    <= inval ? icache_pkg::ICACHE_INVALIDATE : icache_pkg::ICACHE_FETCH;
        exp_miss  <= miss;
        exp_drop  <= drop;
        do @(posedge clk); while (!req_ready);
        miss_allowed <= miss;
        miss_line    <= {addr[31:4], 4'h0};
        if (!inval && !drop) begin
            exp_word[tail] <= addr ^ PATTERN;
            tail           <= tail + 1'b1;
        end
        if (drop) begin
            req_valid  <= 1'b0;
            ctrl.flush <= 1'b1;
            repeat (3) @(posedge clk);
            ctrl.flush <= 1'b0;
        end else if (stall) begin
            req_valid  <= 1'b0;
            ctrl.stall <= 1'b1;
            do @(posedge clk); while (!rdata_valid);
            repeat (3) @(posedge clk);
            ctrl.stall <= 1'b0;
        end
    endtask

    task automatic go_idle();
        req_valid <= 1'b0;
        exp_miss  <= 1'b0;
        exp_drop  <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the cache stopped answering requests");
        fail_run();
    end

    initial begin
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        ctrl         = '0;
        exp_miss     = 1'b0;
        exp_drop     = 1'b0;
        miss_allowed = 1'b0;
        miss_line    = '0;
        tail         = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        // cold miss, then the rest of the line streams as hits
        send_req(32'h0000_0100, 1'b0, 1'b1, 1'b0, 1'b0);
        send_req(32'h0000_0104, 1'b0, 1'b0, 1'b0, 1'b0);
        send_req(32'h0000_0108, 1'b0, 1'b0, 1'b0, 1'b0);
        send_req(32'h0000_010c, 1'b0, 1'b0, 1'b0, 1'b0);
        go_idle();
        // lines A, B and C share set 3
        send_req(32'h0000_1030, 1'b0, 1'b1, 1'b0, 1'b0);
        send_req(32'h0000_2030, 1'b0, 1'b1, 1'b0, 1'b0);
        send_req(32'h0000_1034, 1'b0, 1'b0, 1'b0, 1'b0);
        send_req(32'h0000_3030, 1'b0, 1'b1, 1'b0, 1'b0);
        send_req(32'h0000_1038, 1'b0, 1'b0, 1'b0, 1'b0);
        send_req(32'h0000_203c, 1'b0, 1'b1, 1'b0, 1'b0);
        go_idle();
        // index invalidate of set 0
        send_req(32'h0000_0100, 1'b1, 1'b0, 1'b0, 1'b0);
        send_req(32'h0000_0104, 1'b0, 1'b1, 1'b0, 1'b0);
        go_idle();
        // flushed lookup, then the same line for real
        send_req(32'h0000_5050, 1'b0, 1'b0, 1'b1, 1'b0);
        send_req(32'h0000_5050, 1'b0, 1'b1, 1'b0, 1'b0);
        send_req(32'h0000_5054, 1'b0, 1'b0, 1'b0, 1'b0);
        go_idle();
        // stall on a hit and on a refill
        send_req(32'h0000_5058, 1'b0, 1'b0, 1'b0, 1'b1);
        send_req(32'h0000_6064, 1'b0, 1'b1, 1'b0, 1'b1);
        send_req(32'h0000_6068, 1'b0, 1'b0, 1'b0, 1'b0);
        go_idle();
        repeat (4) @(posedge clk);
        if (head != tail) begin
            $display("some expected words were never delivered");
            fail_run();
        end else if (icache_top_i.icache_assert_i.fail_count != 0) begin
            $display("a protocol check failed inside the cache");
            fail_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/icache_mem_model.sv
`default_nettype none

module icache_mem_model #(
    parameter int          OFFSET_WIDTH = 2,
    parameter logic [31:0] PATTERN      = 32'h0
) (
    input  logic                                                clk,
    input  logic                                                mem_req,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]                   mem_addr,
    output logic                                                mem_addr_ok,
    output logic                                                mem_data_ok,
    output logic [icache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] mem_line
);

    timeunit 1ns;
    timeprecision 1ps;

    integer                            seed = 94;
    int                                delay;
    logic [icache_pkg::ADDR_WIDTH-1:0] line_addr;

    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line    = '0;
        forever begin
            @(posedge clk);
            if (mem_req) begin
                line_addr = mem_addr;
                delay = {$random(seed)} % 4;
                repeat (delay) @(posedge clk);
                mem_addr_ok <= 1'b1;
                @(posedge clk);
                mem_addr_ok <= 1'b0;
                delay = {$random(seed)} % 4;
                repeat (delay) @(posedge clk);
                // every word is its own byte address xor the pattern
                for (int i = 0; i < 2 ** OFFSET_WIDTH; i++)
                    mem_line[i*32 +: 32] <= (line_addr + 4 * i) ^ PATTERN;
                mem_data_ok <= 1'b1;
                @(posedge clk);
                mem_data_ok <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/icache_assert.sv
`default_nettype none

module icache_assert (
    input logic                              clk,
    input logic                              rstn,
    input logic                              mem_req,
    input logic                              mem_addr_ok,
    input logic                              mem_data_ok,
    input logic                              req_ready,
    input logic                              rdata_valid,
    input logic [icache_pkg::WORD_WIDTH-1:0] rdata,
    input icache_pkg::pipe_ctrl_t            ctrl
);

    timeunit 1ns;
    timeprecision 1ps;

    logic        wait_data;
    logic        rstn_d;
    // number of failed protocol checks
    int unsigned fail_count = 0;

    // one refill in flight between address accept and data strobe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wait_data <= 1'b0;
            rstn_d    <= 1'b0;
        end else begin
            rstn_d <= 1'b1;
            if (mem_req && mem_addr_ok)
                wait_data <= 1'b1;
            else if (mem_data_ok)
                wait_data <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_addr_ok) |=> mem_req)
        else begin
            $error("mem_req dropped before the address was accepted");
            fail_count++;
        end

    single_txn: assert property (@(posedge clk) disable iff (!rstn)
        wait_data |-> !mem_req)
        else begin
            $error("second mem_req issued before the line arrived");
            fail_count++;
        end

    ready_after_reset: assert property (@(posedge clk)
        (rstn && !rstn_d) |-> !req_ready)
        else begin
            $error("req_ready high in the first cycle after reset");
            fail_count++;
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        (rdata_valid && ctrl.stall) |=> (rdata_valid && $stable(rdata)))
        else begin
            $error("rdata or rdata_valid changed while stalled");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: source/icache_top.sv
`default_nettype none

module icache_top #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                                                clk,
    input  logic                                                rstn,
    input  logic                                                req_valid,
    input  icache_pkg::fetch_req_t                              req,
    input  icache_pkg::pipe_ctrl_t                              ctrl,
    input  logic                                                mem_addr_ok,
    input  logic                                                mem_data_ok,
    input  logic [icache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] mem_line,
    output logic                                                req_ready,
    output logic                                                rdata_valid,
    output logic [icache_pkg::WORD_WIDTH-1:0]                   rdata,
    output logic                                                mem_req,
    output logic [icache_pkg::ADDR_WIDTH-1:0]                   mem_addr
);

    localparam int LINE_WIDTH = icache_pkg::WORD_WIDTH * (2 ** OFFSET_WIDTH);

    logic [icache_pkg::ADDR_WIDTH-1:0] buf_addr;
    logic [LINE_WIDTH-1:0]             way0_line;
    logic [LINE_WIDTH-1:0]             way1_line;
    logic [1:0]                        hit;
    logic [1:0]                        way_we;
    logic                              victim;
    logic                              buf_we;
    logic                              inval_en;
    logic                              use_valid;
    logic                              use_way;
    logic                              sel_way;
    logic                              sel_return;
    logic                              hold_en;

    // line aligned refill address
    assign mem_addr = {buf_addr[icache_pkg::ADDR_WIDTH-1:OFFSET_WIDTH+2],
                       {(OFFSET_WIDTH+2){1'b0}}};

    icache_ctrl icache_ctrl_i (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_op      (req.op),
        .ctrl        (ctrl),
        .hit         (hit),
        .victim      (victim),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .req_ready   (req_ready),
        .mem_req     (mem_req),
        .buf_we      (buf_we),
        .way_we      (way_we),
        .inval_en    (inval_en),
        .use_valid   (use_valid),
        .use_way     (use_way),
        .sel_way     (sel_way),
        .sel_return  (sel_return),
        .hold_en     (hold_en),
        .rdata_valid (rdata_valid)
    );

    icache_tagv_ram #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) icache_tagv_ram_i (
        .clk      (clk),
        .rstn     (rstn),
        .rd_en    (buf_we),
        .rd_addr  (req.addr),
        .buf_addr (buf_addr),
        .way_we   (way_we),
        .inval_en (inval_en),
        .hit      (hit)
    );

    icache_data_ram #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) icache_data_ram_i (
        .clk       (clk),
        .rd_en     (buf_we),
        .rd_addr   (req.addr),
        .buf_addr  (buf_addr),
        .way_we    (way_we),
        .mem_line  (mem_line),
        .way0_line (way0_line),
        .way1_line (way1_line)
    );

    icache_lru #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) icache_lru_i (
        .clk       (clk),
        .rstn      (rstn),
        .buf_addr  (buf_addr),
        .use_valid (use_valid),
        .use_way   (use_way),
        .victim    (victim)
    );

    icache_read_path #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) icache_read_path_i (
        .clk        (clk),
        .rstn       (rstn),
        .buf_we     (buf_we),
        .req        (req),
        .way0_line  (way0_line),
        .way1_line  (way1_line),
        .mem_line   (mem_line),
        .sel_way    (sel_way),
        .sel_return (sel_return),
        .hold_en    (hold_en),
        .buf_addr   (buf_addr),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// File: source/icache_read_path.sv
`default_nettype none

module icache_read_path #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                                                clk,
    input  logic                                                rstn,
    input  logic                                                buf_we,
    input  icache_pkg::fetch_req_t                              req,
    input  logic [icache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] way0_line,
    input  logic [icache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] way1_line,
    input  logic [icache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] mem_line,
    input  logic                                                sel_way,
    input  logic                                                sel_return,
    input  logic                                                hold_en,
    output logic [icache_pkg::ADDR_WIDTH-1:0]                   buf_addr,
    output logic [icache_pkg::WORD_WIDTH-1:0]                   rdata
);

    localparam int LINE_WIDTH = icache_pkg::WORD_WIDTH * (2 ** OFFSET_WIDTH);

    logic [LINE_WIDTH-1:0]             src_line;
    logic [OFFSET_WIDTH-1:0]           word_sel;
    logic [icache_pkg::WORD_WIDTH-1:0] sel_word;
    logic [icache_pkg::WORD_WIDTH-1:0] hold_q;
    logic                              held_q;

    // request buffer, the set index here also drives writes and the LRU
    always_ff @(posedge clk) begin
        if (buf_we)
            buf_addr <= req.addr;
    end

    assign word_sel = buf_addr[OFFSET_WIDTH+1:2];

    // refill forward takes priority over the way data
    always_comb begin
        if (sel_return)
            src_line = mem_line;
        else
            src_line = sel_way ? way1_line : way0_line;
        sel_word = src_line[word_sel*icache_pkg::WORD_WIDTH +: icache_pkg::WORD_WIDTH];
    end

    ///////////////////////////////////////////////////////////////////////
    // stall hold

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            held_q <= 1'b0;
        else
            held_q <= hold_en;
    end

    always_ff @(posedge clk) begin
        if (hold_en)
            hold_q <= rdata;
    end

    assign rdata = held_q ? hold_q : sel_word;

endmodule

`default_nettype wire

// File: source/icache_lru.sv
`default_nettype none

module icache_lru #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] buf_addr,
    input  logic                             use_valid,
    input  logic                             use_way,
    output logic                             victim
);

    logic [2**INDEX_WIDTH-1:0] lru_q;
    logic [INDEX_WIDTH-1:0]    buf_index;

    assign buf_index = buf_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];

    // each bit names the way not used most recently
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            lru_q <= '0;
        else if (use_valid)
            lru_q[buf_index] <= ~use_way;
    end

    assign victim = lru_q[buf_index];

endmodule

`default_nettype wire

// File: source/icache_data_ram.sv
`default_nettype none

module icache_data_ram #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                                             clk,
    input  logic                                             rd_en,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]                rd_addr,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]                buf_addr,
    input  logic [1:0]                                       way_we,
    input  logic [icache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] mem_line,
    output logic [icache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] way0_line,
    output logic [icache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] way1_line
);

    localparam int LINE_WIDTH = icache_pkg::WORD_WIDTH * (2 ** OFFSET_WIDTH);
    localparam int SETS       = 2 ** INDEX_WIDTH;

    logic [LINE_WIDTH-1:0]  line_mem [2][SETS];
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [INDEX_WIDTH-1:0] buf_index;

    assign rd_index  = rd_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign buf_index = buf_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];

    // whole-line refill, synchronous read on acceptance
    always_ff @(posedge clk) begin
        if (way_we[0])
            line_mem[0][buf_index] <= mem_line;
        if (way_we[1])
            line_mem[1][buf_index] <= mem_line;
        if (rd_en) begin
            way0_line <= line_mem[0][rd_index];
            way1_line <= line_mem[1][rd_index];
        end
    end

endmodule

`default_nettype wire

// File: source/icache_tagv_ram.sv
`default_nettype none

module icache_tagv_ram #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             rd_en,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] buf_addr,
    input  logic [1:0]                       way_we,
    input  logic                             inval_en,
    output logic [1:0]                       hit
);

    localparam int TAG_WIDTH = icache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int SETS      = 2 ** INDEX_WIDTH;

    logic [TAG_WIDTH-1:0]   tag_mem [2][SETS];
    logic [SETS-1:0]        valid_mem [2];
    logic [TAG_WIDTH-1:0]   tag_q [2];
    logic [1:0]             valid_q;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [INDEX_WIDTH-1:0] buf_index;
    logic [TAG_WIDTH-1:0]   buf_tag;

    assign rd_index  = rd_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign buf_index = buf_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign buf_tag   = buf_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];

    // valid bits, invalidate clears both ways of the set
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 2'b00;
            for (int w = 0; w < 2; w++)
                valid_mem[w] <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (inval_en)
                    valid_mem[w][buf_index] <= 1'b0;
                else if (way_we[w])
                    valid_mem[w][buf_index] <= 1'b1;
                if (rd_en)
                    valid_q[w] <= valid_mem[w][rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way_we[w])
                tag_mem[w][buf_index] <= buf_tag;
            if (rd_en)
                tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++)
            hit[w] = valid_q[w] && (tag_q[w] == buf_tag);
    end

endmodule

`default_nettype wire

// File: source/icache_ctrl.sv
`default_nettype none

module icache_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    input  icache_pkg::icache_op_e req_op,
    input  icache_pkg::pipe_ctrl_t ctrl,
    input  logic [1:0]             hit,
    input  logic                   victim,
    input  logic                   mem_addr_ok,
    input  logic                   mem_data_ok,
    output logic                   req_ready,
    output logic                   mem_req,
    output logic                   buf_we,
    output logic [1:0]             way_we,
    output logic                   inval_en,
    output logic                   use_valid,
    output logic                   use_way,
    output logic                   sel_way,
    output logic                   sel_return,
    output logic                   hold_en,
    output logic                   rdata_valid
);

    icache_pkg::icache_state_e state;
    icache_pkg::icache_state_e next_state;
    icache_pkg::icache_state_e dispatch_state;
    logic                      rstn_q;
    logic                      ready_c;
    logic                      accept;
    logic                      hit_any;

    assign hit_any   = |hit;
    // way 0 wins a double hit
    assign sel_way   = ~hit[0];
    assign req_ready = ready_c & rstn_q;
    assign accept    = req_valid & req_ready;

    // keeps ready low for one cycle after reset release
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_q <= 1'b0;
            state  <= icache_pkg::IDLE;
        end else begin
            rstn_q <= 1'b1;
            state  <= next_state;
        end
    end

    always_comb begin
        case (state)
            icache_pkg::IDLE,
            icache_pkg::FLUSH,
            icache_pkg::STALL:  ready_c = ~ctrl.stall;
            // hit streams the next request, flush discards it
            icache_pkg::LOOKUP: ready_c = ~ctrl.stall & (ctrl.flush | hit_any);
            default:            ready_c = 1'b0;
        endcase
    end

    always_comb begin
        if (!accept)
            dispatch_state = icache_pkg::IDLE;
        else if (req_op == icache_pkg::ICACHE_INVALIDATE)
            dispatch_state = icache_pkg::OPERATION;
        else
            dispatch_state = icache_pkg::LOOKUP;
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: next_state = dispatch_state;
            icache_pkg::LOOKUP: begin
                if (ctrl.flush)
                    next_state = icache_pkg::FLUSH;
                else if (!hit_any)
                    next_state = mem_addr_ok ? icache_pkg::MISS_WAIT : icache_pkg::MISS_REQ;
                else if (ctrl.stall)
                    next_state = icache_pkg::LOOKUP;
                else
                    next_state = dispatch_state;
            end
            icache_pkg::MISS_REQ: begin
                if (mem_addr_ok)
                    next_state = icache_pkg::MISS_WAIT;
            end
            icache_pkg::MISS_WAIT: begin
                if (mem_data_ok)
                    next_state = ctrl.stall ? icache_pkg::STALL : icache_pkg::IDLE;
            end
            icache_pkg::STALL: begin
                if (!ctrl.stall)
                    next_state = dispatch_state;
            end
            icache_pkg::FLUSH: begin
                if (!ctrl.flush)
                    next_state = dispatch_state;
            end
            default: next_state = icache_pkg::IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // output decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_req     = 1'b0;
        way_we      = 2'b00;
        inval_en    = 1'b0;
        use_valid   = 1'b0;
        use_way     = 1'b0;
        sel_return  = 1'b0;
        hold_en     = 1'b0;
        rdata_valid = 1'b0;
        // requests accepted under flush never reach the buffer
        buf_we = accept && (next_state == icache_pkg::LOOKUP ||
                            next_state == icache_pkg::OPERATION);
        case (state)
            icache_pkg::LOOKUP: begin
                if (next_state == icache_pkg::MISS_REQ || next_state == icache_pkg::MISS_WAIT)
                    mem_req = 1'b1;
                if (next_state != icache_pkg::FLUSH && hit_any) begin
                    rdata_valid = 1'b1;
                    use_valid   = ~ctrl.stall;
                    use_way     = sel_way;
                end
            end
            icache_pkg::MISS_REQ: mem_req = 1'b1;
            icache_pkg::MISS_WAIT: begin
                if (mem_data_ok) begin
                    // refill the victim and forward the word
                    way_we      = victim ? 2'b10 : 2'b01;
                    use_valid   = 1'b1;
                    use_way     = victim;
                    sel_return  = 1'b1;
                    rdata_valid = 1'b1;
                    hold_en     = ctrl.stall;
                end
            end
            icache_pkg::STALL: begin
                rdata_valid = 1'b1;
                hold_en     = ctrl.stall;
            end
            icache_pkg::OPERATION: inval_en = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // byte address and instruction word
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;

    typedef enum logic {
        ICACHE_FETCH      = 1'b0,
        ICACHE_INVALIDATE = 1'b1
    } icache_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        STALL,
        FLUSH,
        OPERATION
    } icache_state_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        icache_op_e            op;
    } fetch_req_t;

    // pipeline control levels
    typedef struct packed {
        logic stall;
        logic flush;
    } pipe_ctrl_t;

endpackage

`default_nettype wire
